// File: hdl/axi_remap_pkg.sv
package axi_remap_pkg;

  // bus widths
  localparam int unsigned id_width       = 4;
  localparam int unsigned slv_addr_width = 32; // upstream address
  localparam int unsigned mst_addr_width = 12; // memory side address
  localparam int unsigned data_width     = 32;
  localparam int unsigned user_width     = 1;

  typedef logic [id_width-1:0]       id_t;
  typedef logic [slv_addr_width-1:0] slv_addr_t;
  typedef logic [mst_addr_width-1:0] mst_addr_t;
  typedef logic [data_width-1:0]     data_t;
  typedef logic [data_width/8-1:0]   strb_t;     // one bit per byte lane
  typedef logic [user_width-1:0]     user_t;

  // response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // aw channels, only addr width differs
  typedef struct packed {
    id_t        id;
    slv_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    logic [5:0] atop;
    user_t      user;
  } slv_aw_chan_t;

  typedef struct packed {
    id_t        id;
    mst_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    logic [5:0] atop;
    user_t      user;
  } mst_aw_chan_t;

  // ar channels, no atop
  typedef struct packed {
    id_t        id;
    slv_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    user_t      user;
  } slv_ar_chan_t;

  typedef struct packed {
    id_t        id;
    mst_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic       lock;
    logic [3:0] cache;
    logic [2:0] prot;
    logic [3:0] qos;
    logic [3:0] region;
    user_t      user;
  } mst_ar_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
    user_t user;
  } w_chan_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
    user_t      user;
  } b_chan_t;

  typedef struct packed {
    id_t        id;
    data_t      data;
    logic [1:0] resp;
    logic       last;
    user_t      user;
  } r_chan_t;

  // request bundles, one per port address width
  typedef struct packed {
    slv_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    slv_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } slv_req_t;

  typedef struct packed {
    mst_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    mst_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } mst_req_t;

  // shared by both ports
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
  } resp_t;

  // one remap window
  typedef struct packed {
    logic      enable;
    slv_addr_t base;   // compared after masking
    slv_addr_t mask;
    mst_addr_t offset; // added after base is removed
  } region_cfg_t;

endpackage

// File: hdl/addr_remap_table.sv
`timescale 1ns/1ps

module addr_remap_table import axi_remap_pkg::*; #(
  parameter int unsigned num_regions = 4,
  localparam int unsigned idx_width = (num_regions > 1) ? $clog2(num_regions) : 1
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // config write port
  input  logic                 cfg_we_i,
  input  logic [idx_width-1:0] cfg_idx_i,
  input  region_cfg_t          cfg_region_i,
  // aw and ar lookups side by side
  input  slv_addr_t            slv_aw_addr_i,
  input  slv_addr_t            slv_ar_addr_i,
  output mst_addr_t            mst_aw_addr_o,
  output mst_addr_t            mst_ar_addr_o
);

  region_cfg_t cfg_q [num_regions]; // region entries

  // one entry written per edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < num_regions; i++) begin
        cfg_q[i].enable <= 1'b0; // all windows off
      end
    end else if (cfg_we_i) begin
      cfg_q[cfg_idx_i] <= cfg_region_i; // visible next cycle
    end
  end

  // priority search over the table
  // lowest matching index wins and later hits are ignored
  function automatic mst_addr_t lookup(slv_addr_t addr);
    slv_addr_t moved;
    logic      hit;
    lookup = addr[mst_addr_width-1:0]; // low bits when nothing hits
    hit    = 1'b0;
    for (int i = 0; i < num_regions; i++) begin
      if (!hit && cfg_q[i].enable &&
          ((addr & cfg_q[i].mask) == cfg_q[i].base)) begin
        hit    = 1'b1;
        // rebase into the window then shift by the offset
        moved  = addr - cfg_q[i].base + slv_addr_t'(cfg_q[i].offset);
        lookup = moved[mst_addr_width-1:0]; // wraps in 12 bits
      end
    end
  endfunction

  // aw lookup
  always_comb begin
    mst_aw_addr_o = lookup(slv_aw_addr_i);
  end

  // ar lookup independent of aw
  always_comb begin
    mst_ar_addr_o = lookup(slv_ar_addr_i);
  end

endmodule

// File: hdl/axi_modify_address.sv
`timescale 1ns/1ps

// swaps aw/ar addresses for the ones the table returns
module axi_modify_address import axi_remap_pkg::*; (
  // slave side
  input  slv_req_t  slv_req_i,
  output resp_t     slv_resp_o,
  output slv_addr_t slv_aw_addr_o, // to the remap table
  output slv_addr_t slv_ar_addr_o,
  // master side
  output mst_req_t  mst_req_o,
  input  resp_t     mst_resp_i,
  input  mst_addr_t mst_aw_addr_i, // back from the table
  input  mst_addr_t mst_ar_addr_i
);

  // raw addresses go out for lookup
  assign slv_aw_addr_o = slv_req_i.aw.addr;
  assign slv_ar_addr_o = slv_req_i.ar.addr;

  always_comb begin
    // aw fields copied with addr replaced
    mst_req_o.aw.id     = slv_req_i.aw.id;
    mst_req_o.aw.addr   = mst_aw_addr_i;
    mst_req_o.aw.len    = slv_req_i.aw.len;
    mst_req_o.aw.size   = slv_req_i.aw.size;
    mst_req_o.aw.burst  = slv_req_i.aw.burst;
    mst_req_o.aw.lock   = slv_req_i.aw.lock;
    mst_req_o.aw.cache  = slv_req_i.aw.cache;
    mst_req_o.aw.prot   = slv_req_i.aw.prot;
    mst_req_o.aw.qos    = slv_req_i.aw.qos;
    mst_req_o.aw.region = slv_req_i.aw.region;
    mst_req_o.aw.atop   = slv_req_i.aw.atop;
    mst_req_o.aw.user   = slv_req_i.aw.user;
    mst_req_o.aw_valid  = slv_req_i.aw_valid;
    // w and response readies untouched
    mst_req_o.w         = slv_req_i.w;
    mst_req_o.w_valid   = slv_req_i.w_valid;
    mst_req_o.b_ready   = slv_req_i.b_ready;
    // ar treated like aw but without atop
    mst_req_o.ar.id     = slv_req_i.ar.id;
    mst_req_o.ar.addr   = mst_ar_addr_i;
    mst_req_o.ar.len    = slv_req_i.ar.len;
    mst_req_o.ar.size   = slv_req_i.ar.size;
    mst_req_o.ar.burst  = slv_req_i.ar.burst;
    mst_req_o.ar.lock   = slv_req_i.ar.lock;
    mst_req_o.ar.cache  = slv_req_i.ar.cache;
    mst_req_o.ar.prot   = slv_req_i.ar.prot;
    mst_req_o.ar.qos    = slv_req_i.ar.qos;
    mst_req_o.ar.region = slv_req_i.ar.region;
    mst_req_o.ar.user   = slv_req_i.ar.user;
    mst_req_o.ar_valid  = slv_req_i.ar_valid;
    mst_req_o.r_ready   = slv_req_i.r_ready;
  end

  // responses carry no address
  assign slv_resp_o = mst_resp_i;

endmodule

// File: hdl/axi_req_cut.sv
`timescale 1ns/1ps

// single-entry register slice on the request channels
module axi_req_cut import axi_remap_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // upstream
  input  mst_req_t in_req_i,
  output resp_t    in_resp_o,
  // downstream
  output mst_req_t out_req_o,
  input  resp_t    out_resp_i
);

  // bit positions in the flag vectors
  localparam int unsigned ch_aw = 0;
  localparam int unsigned ch_w  = 1;
  localparam int unsigned ch_ar = 2;

  logic [2:0] full_q;    // slot occupied
  logic [2:0] in_valid;
  logic [2:0] in_ready;
  logic [2:0] out_ready;

  mst_aw_chan_t aw_q; // slot payloads
  w_chan_t      w_q;
  mst_ar_chan_t ar_q;

  assign in_valid[ch_aw]  = in_req_i.aw_valid;
  assign in_valid[ch_w]   = in_req_i.w_valid;
  assign in_valid[ch_ar]  = in_req_i.ar_valid;
  assign out_ready[ch_aw] = out_resp_i.aw_ready;
  assign out_ready[ch_w]  = out_resp_i.w_ready;
  assign out_ready[ch_ar] = out_resp_i.ar_ready;

  // free slot, or the held beat leaves this cycle
  assign in_ready = ~full_q | out_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= '0;
    end else begin
      // refill when draining, else keep
      full_q <= (in_ready & in_valid) | (~in_ready & full_q);
    end
  end

  // payloads load only on an input transfer
  always_ff @(posedge clk_i) begin
    if (in_valid[ch_aw] && in_ready[ch_aw]) begin
      aw_q <= in_req_i.aw;
    end
    if (in_valid[ch_w] && in_ready[ch_w]) begin
      w_q <= in_req_i.w;
    end
    if (in_valid[ch_ar] && in_ready[ch_ar]) begin
      ar_q <= in_req_i.ar;
    end
  end

  always_comb begin
    out_req_o.aw       = aw_q;
    out_req_o.aw_valid = full_q[ch_aw];
    out_req_o.w        = w_q;
    out_req_o.w_valid  = full_q[ch_w];
    out_req_o.ar       = ar_q;
    out_req_o.ar_valid = full_q[ch_ar];
    out_req_o.b_ready  = in_req_i.b_ready; // b/r not cut
    out_req_o.r_ready  = in_req_i.r_ready;
  end

  always_comb begin
    in_resp_o          = out_resp_i; // b and r straight through
    in_resp_o.aw_ready = in_ready[ch_aw];
    in_resp_o.w_ready  = in_ready[ch_w];
    in_resp_o.ar_ready = in_ready[ch_ar];
  end

endmodule

// File: hdl/axi_sram_slave.sv
`timescale 1ns/1ps

// word wide memory, one beat per transaction
module axi_sram_slave import axi_remap_pkg::*; #(
  parameter int unsigned mem_words = 256
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  mst_req_t req_i,
  output resp_t    resp_o
);

  localparam int unsigned idx_width  = (mem_words > 1) ? $clog2(mem_words) : 1;
  localparam int unsigned byte_lanes = data_width / 8;
  localparam int unsigned mem_bytes  = mem_words * byte_lanes; // first illegal address

  data_t mem_q [mem_words]; // contents not reset

  logic                 wr_fire;
  logic                 rd_fire;
  logic                 wr_err;
  logic                 rd_err;
  logic [idx_width-1:0] wr_idx;
  logic [idx_width-1:0] rd_idx;

  // b side state
  logic       b_valid_q;
  id_t        b_id_q;
  logic [1:0] b_resp_q;

  // r side state
  logic       r_valid_q;
  id_t        r_id_q;
  logic [1:0] r_resp_q;
  data_t      r_data_q;

  // aw and w go together, only when b slot is free
  assign wr_fire = req_i.aw_valid && req_i.w_valid && !b_valid_q;
  assign rd_fire = req_i.ar_valid && !r_valid_q;

  assign wr_err = req_i.aw.addr >= mem_bytes;
  assign rd_err = req_i.ar.addr >= mem_bytes;
  assign wr_idx = req_i.aw.addr[idx_width+1:2]; // word index
  assign rd_idx = req_i.ar.addr[idx_width+1:2];

  // write path, strobed bytes only
  always_ff @(posedge clk_i) begin
    if (wr_fire && !wr_err) begin
      for (int i = 0; i < byte_lanes; i++) begin
        if (req_i.w.strb[i]) begin
          mem_q[wr_idx][8*i +: 8] <= req_i.w.data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_fire) begin
      b_valid_q <= 1'b1;
    end else if (req_i.b_ready) begin
      b_valid_q <= 1'b0; // taken
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_id_q   <= req_i.aw.id;
      b_resp_q <= wr_err ? resp_slverr : resp_okay; // dropped write reports error
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_fire) begin
      r_valid_q <= 1'b1;
    end else if (req_i.r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  // read data captured at accept, held until taken
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_id_q   <= req_i.ar.id;
      r_resp_q <= rd_err ? resp_slverr : resp_okay;
      r_data_q <= rd_err ? '0 : mem_q[rd_idx]; // zero on error
    end
  end

  always_comb begin
    resp_o.aw_ready = wr_fire;
    resp_o.w_ready  = wr_fire; // same cycle as aw
    resp_o.ar_ready = !r_valid_q;
    resp_o.b.id     = b_id_q;
    resp_o.b.resp   = b_resp_q;
    resp_o.b.user   = '0;
    resp_o.b_valid  = b_valid_q;
    resp_o.r.id     = r_id_q;
    resp_o.r.data   = r_data_q;
    resp_o.r.resp   = r_resp_q;
    resp_o.r.last   = 1'b1; // single beat
    resp_o.r.user   = '0;
    resp_o.r_valid  = r_valid_q;
  end

endmodule

// File: hdl/axi_remap_top.sv
`timescale 1ns/1ps

// remap table + connector + request cut + memory
module axi_remap_top import axi_remap_pkg::*; #(
  parameter int unsigned num_regions = 4,
  parameter int unsigned mem_words   = 256,
  localparam int unsigned idx_width = (num_regions > 1) ? $clog2(num_regions) : 1
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 cfg_we_i,
  input  logic [idx_width-1:0] cfg_idx_i,
  input  region_cfg_t          cfg_region_i,
  input  slv_req_t             slv_req_i,
  output resp_t                slv_resp_o
);

  slv_addr_t slv_aw_addr; // to table
  slv_addr_t slv_ar_addr;
  mst_addr_t mst_aw_addr; // from table
  mst_addr_t mst_ar_addr;
  mst_req_t  mod_req;     // connector -> cut
  resp_t     mod_resp;
  mst_req_t  cut_req;     // cut -> memory
  resp_t     cut_resp;

  addr_remap_table #(
    .num_regions ( num_regions )
  ) i_table (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .cfg_we_i      ( cfg_we_i     ),
    .cfg_idx_i     ( cfg_idx_i    ),
    .cfg_region_i  ( cfg_region_i ),
    .slv_aw_addr_i ( slv_aw_addr  ),
    .slv_ar_addr_i ( slv_ar_addr  ),
    .mst_aw_addr_o ( mst_aw_addr  ),
    .mst_ar_addr_o ( mst_ar_addr  )
  );

  axi_modify_address i_modify (
    .slv_req_i     ( slv_req_i   ),
    .slv_resp_o    ( slv_resp_o  ),
    .slv_aw_addr_o ( slv_aw_addr ),
    .slv_ar_addr_o ( slv_ar_addr ),
    .mst_req_o     ( mod_req     ),
    .mst_resp_i    ( mod_resp    ),
    .mst_aw_addr_i ( mst_aw_addr ),
    .mst_ar_addr_i ( mst_ar_addr )
  );

  axi_req_cut i_cut (
    .clk_i      ( clk_i    ),
    .reset_i    ( reset_i  ),
    .in_req_i   ( mod_req  ),
    .in_resp_o  ( mod_resp ),
    .out_req_o  ( cut_req  ),
    .out_resp_i ( cut_resp )
  );

  axi_sram_slave #(
    .mem_words ( mem_words )
  ) i_sram (
    .clk_i   ( clk_i    ),
    .reset_i ( reset_i  ),
    .req_i   ( cut_req  ),
    .resp_o  ( cut_resp )
  );

endmodule

// File: sim/tb_axi_remap.sv
`timescale 1ns/1ps

module tb_axi_remap import axi_remap_pkg::*; ();

  localparam int num_regions = 4;
  localparam int mem_words   = 256;
  localparam int max_wait    = 200; // cycles per wait loop

  logic        clk_i;
  logic        reset_i;
  logic        cfg_we_i;
  logic [1:0]  cfg_idx_i;
  region_cfg_t cfg_region_i;
  slv_req_t    slv_req_i;
  resp_t       slv_resp_o;

  // reference state
  region_cfg_t model_cfg [num_regions];
  data_t       model_mem [mem_words];
  logic        written   [mem_words]; // word has known contents
  logic [31:0] seed;
  int          errors;
  int          proto_errors;
  int          timeouts;

  axi_remap_top dut (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .cfg_we_i     ( cfg_we_i     ),
    .cfg_idx_i    ( cfg_idx_i    ),
    .cfg_region_i ( cfg_region_i ),
    .slv_req_i    ( slv_req_i    ),
    .slv_resp_o   ( slv_resp_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i; // 100 ns period
  end

  function automatic logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223; // lcg step
    return seed;
  endfunction

  // remap rule scanned from the top so the lowest hit is left standing
  function automatic mst_addr_t expect_addr(slv_addr_t a);
    slv_addr_t sum;
    expect_addr = a[11:0];
    for (int i = num_regions - 1; i >= 0; i--) begin
      if (model_cfg[i].enable && ((a & model_cfg[i].mask) == model_cfg[i].base)) begin
        sum = a - model_cfg[i].base + {20'h0, model_cfg[i].offset};
        expect_addr = sum[11:0];
      end
    end
  endfunction

  task automatic finish_run();
    $display("errors: %0d value, %0d protocol, %0d timeout", errors, proto_errors, timeouts);
    if (errors == 0 && proto_errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  task automatic check_b(input string name, input b_chan_t got, input b_chan_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_r(input string name, input r_chan_t got, input r_chan_t exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic timed_out(input string what);
    timeouts++;
    $display("timeout after %0d cycles waiting for %s", max_wait, what);
  endtask

  task automatic send_write(input slv_addr_t addr, input data_t data, input strb_t strb,
                            input id_t id);
    int   cycles;
    logic aw_done;
    logic w_done;
    @(negedge clk_i);
    slv_req_i.aw.addr  = addr;
    slv_req_i.aw.id    = id;
    slv_req_i.aw_valid = 1'b1;
    slv_req_i.w.data   = data;
    slv_req_i.w.strb   = strb;
    slv_req_i.w_valid  = 1'b1;
    aw_done = 1'b0;
    w_done  = 1'b0;
    cycles  = 0;
    while (!(aw_done && w_done) && cycles < max_wait) begin
      if (slv_req_i.aw_valid && slv_resp_o.aw_ready) aw_done = 1'b1; // taken next edge
      if (slv_req_i.w_valid && slv_resp_o.w_ready) w_done = 1'b1;
      @(negedge clk_i);
      if (aw_done) slv_req_i.aw_valid = 1'b0;
      if (w_done) slv_req_i.w_valid = 1'b0;
      cycles++;
    end
    if (!(aw_done && w_done)) timed_out("aw/w acceptance");
  endtask

  task automatic send_read(input slv_addr_t addr, input id_t id);
    int cycles;
    @(negedge clk_i);
    slv_req_i.ar.addr  = addr;
    slv_req_i.ar.id    = id;
    slv_req_i.ar_valid = 1'b1;
    cycles = 0;
    while (slv_req_i.ar_valid && cycles < max_wait) begin
      if (slv_resp_o.ar_ready) begin
        @(negedge clk_i);
        slv_req_i.ar_valid = 1'b0;
      end else begin
        @(negedge clk_i);
      end
      cycles++;
    end
    if (slv_req_i.ar_valid) timed_out("ar acceptance");
  endtask

  // holds b_ready low a few cycles and watches the payload
  task automatic take_b(input b_chan_t exp);
    int          cycles;
    int          hold;
    b_chan_t     first;
    logic [31:0] r;
    cycles = 0;
    while (!slv_resp_o.b_valid && cycles < max_wait) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!slv_resp_o.b_valid) begin
      timed_out("b_valid");
    end else begin
      first = slv_resp_o.b;
      check_b("slv_resp_o.b", first, exp);
      r    = rand32();
      hold = r % 32'd4;
      repeat (hold) begin
        @(negedge clk_i);
        if (!slv_resp_o.b_valid) begin
          proto_errors++;
          $display("write response valid dropped before it was taken");
        end
        check_b("slv_resp_o.b (held)", slv_resp_o.b, first);
      end
      slv_req_i.b_ready = 1'b1;
      @(negedge clk_i);
      slv_req_i.b_ready = 1'b0;
      if (slv_resp_o.b_valid) begin
        proto_errors++;
        $display("write response still valid after it was taken");
      end
    end
  endtask

  task automatic take_r(input r_chan_t exp);
    int          cycles;
    int          hold;
    r_chan_t     first;
    logic [31:0] r;
    cycles = 0;
    while (!slv_resp_o.r_valid && cycles < max_wait) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!slv_resp_o.r_valid) begin
      timed_out("r_valid");
    end else begin
      first = slv_resp_o.r;
      check_r("slv_resp_o.r", first, exp);
      r    = rand32();
      hold = r % 32'd4;
      repeat (hold) begin
        @(negedge clk_i);
        if (!slv_resp_o.r_valid) begin
          proto_errors++;
          $display("read response valid dropped before it was taken");
        end
        check_r("slv_resp_o.r (held)", slv_resp_o.r, first);
      end
      slv_req_i.r_ready = 1'b1;
      @(negedge clk_i);
      slv_req_i.r_ready = 1'b0;
      if (slv_resp_o.r_valid) begin
        proto_errors++;
        $display("read response still valid after it was taken");
      end
    end
  endtask

  task automatic config_region();
    logic [31:0] r;
    region_cfg_t c;
    r = rand32();
    c.mask   = r[0] ? 32'hffff_fc00 : 32'hffff_f800; // two sizes so windows overlap
    c.base   = (32'h0001_0000 | (r & 32'h0000_0c00)) & c.mask;
    c.enable = (r[3:1] != 3'd0);
    c.offset = r[27:16] & 12'hffc; // keep word alignment
    @(negedge clk_i);
    cfg_we_i     = 1'b1;
    cfg_idx_i    = r[5:4];
    cfg_region_i = c;
    @(negedge clk_i);
    cfg_we_i = 1'b0;
    model_cfg[r[5:4]] = c;
  endtask

  // one transaction to a low address or the 0x1_0000 alias window
  task automatic random_op(input logic low_only);
    logic [31:0] r;
    slv_addr_t   addr;
    mst_addr_t   ea;
    logic [7:0]  idx;
    logic        inr;
    id_t         id;
    data_t       data;
    strb_t       strb;
    b_chan_t     exp_b;
    r_chan_t     exp_r;
    r    = rand32();
    addr = (low_only || r[0]) ? (r & 32'h0000_07fc) : (32'h0001_0000 | (r & 32'h0000_0ffc));
    ea   = expect_addr(addr);
    idx  = ea[9:2];
    inr  = (ea < 12'h400);
    id   = r[31:28];
    if (r[1] && (!inr || written[idx])) begin
      exp_r.id   = id;
      exp_r.data = inr ? model_mem[idx] : '0;
      exp_r.resp = inr ? resp_okay : resp_slverr;
      exp_r.last = 1'b1;
      exp_r.user = '0;
      send_read(addr, id);
      if (timeouts == 0) begin
        take_r(exp_r);
      end
    end else begin
      data = rand32();
      strb = written[idx] ? r[19:16] : 4'hf; // full word first time
      exp_b.id   = id;
      exp_b.resp = inr ? resp_okay : resp_slverr;
      exp_b.user = '0;
      send_write(addr, data, strb, id);
      if (timeouts == 0) begin
        take_b(exp_b);
        if (inr) begin
          for (int i = 0; i < 4; i++) begin
            if (strb[i]) model_mem[idx][8*i +: 8] = data[8*i +: 8];
          end
          written[idx] = 1'b1;
        end
      end
    end
  endtask

  initial begin
    seed         = 32'hdab0_5abf;
    errors       = 0;
    proto_errors = 0;
    timeouts     = 0;
    reset_i      = 1'b1;
    cfg_we_i     = 1'b0;
    cfg_idx_i    = '0;
    cfg_region_i = '0;
    slv_req_i    = '0;
    slv_req_i.aw.size  = 3'd2; // single word beats
    slv_req_i.aw.burst = 2'b01;
    slv_req_i.w.last   = 1'b1;
    slv_req_i.ar.size  = 3'd2;
    slv_req_i.ar.burst = 2'b01;
    for (int i = 0; i < num_regions; i++) model_cfg[i] = '0;
    for (int i = 0; i < mem_words; i++) begin
      model_mem[i] = '0;
      written[i]   = 1'b0;
    end
    repeat (10) begin
      @(negedge clk_i);
      if (slv_resp_o.b_valid || slv_resp_o.r_valid) begin
        proto_errors++;
        $display("response valid high during reset");
      end
    end
    reset_i = 1'b0;
    repeat (150) begin
      if (timeouts == 0) random_op(1'b1); // plain pass-through
    end
    repeat (8) begin
      if (timeouts == 0) config_region();
      repeat (40) begin
        if (timeouts == 0) random_op(1'b0);
      end
    end
    finish_run();
  end

endmodule

// File: src.f
hdl/axi_remap_pkg.sv
hdl/addr_remap_table.sv
hdl/axi_modify_address.sv
hdl/axi_req_cut.sv
hdl/axi_sram_slave.sv
hdl/axi_remap_top.sv
sim/tb_axi_remap.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_axi_remap -f src.f &&
out=$(./obj_dir/Vtb_axi_remap) ||
{ echo "$out"; echo "build or run error"; exit 1; }
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
